/* Bender.yml */
package:
  name: usb_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/usb_pkg.sv
      - src/usb_token_decoder.sv
      - src/usb_ctrl_transfer.sv
      - src/usb_std_request.sv
      - src/usb_ctrl_top.sv
  - target: test
    files:
      - testbench/usb_ctrl_tb.sv

/* project.f */
+incdir+src
src/usb_pkg.sv
src/usb_token_decoder.sv
src/usb_ctrl_transfer.sv
src/usb_std_request.sv
src/usb_ctrl_top.sv
testbench/usb_ctrl_tb.sv

/* src/usb_ctrl_top.sv */
module usb_ctrl_top (
  input  logic       clock,
  input  logic       reset,
  input  logic       rx_valid_i,
  input  logic       rx_last_i,
  input  logic [7:0] rx_data_i,
  input  logic       hsk_sent_i,
  input  logic       timeout_i,
  output logic       ctrl_start_o,
  output logic       ctrl_select_o,
  output logic       zdp_o,
  output logic       parity_o,
  output logic       finish_o,
  output logic       pid_error_o,
  output logic [6:0] usb_addr_o,
  output logic       configured_o,
  output logic       stall_o
);
  import usb_pkg::*;

  // Decoder to control stage
  logic       tok_valid;
  usb_token_t tok;
  logic       dat_valid;
  usb_data_t  dat;
  logic       hsk_recv;

  // Control stage to request stage
  usb_req_t   req;
  logic       finish;

  // Fed back to qualify the next SETUP
  logic [6:0] usb_addr;

  usb_token_decoder u_decoder (
    .clock      (clock),
    .reset      (reset),
    .rx_valid_i (rx_valid_i),
    .rx_last_i  (rx_last_i),
    .rx_data_i  (rx_data_i),
    .tok_valid_o(tok_valid),
    .tok_o      (tok),
    .dat_valid_o(dat_valid),
    .dat_o      (dat),
    .hsk_recv_o (hsk_recv),
    .pid_error_o(pid_error_o)
  );

  usb_ctrl_transfer u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .usb_addr_i   (usb_addr),
    .tok_valid_i  (tok_valid),
    .tok_i        (tok),
    .dat_valid_i  (dat_valid),
    .dat_i        (dat),
    .hsk_recv_i   (hsk_recv),
    .hsk_sent_i   (hsk_sent_i),
    .timeout_i    (timeout_i),
    .ctrl_start_o (ctrl_start_o),
    .ctrl_select_o(ctrl_select_o),
    .zdp_o        (zdp_o),
    .parity_o     (parity_o),
    .finish_o     (finish),
    .req_o        (req)
  );

  usb_std_request u_stdreq (
    .clock       (clock),
    .reset       (reset),
    .req_i       (req),
    .finish_i    (finish),
    .usb_addr_o  (usb_addr),
    .configured_o(configured_o),
    .stall_o     (stall_o)
  );

  assign finish_o = finish;
  assign usb_addr_o = usb_addr;

endmodule

/* src/usb_ctrl_transfer.sv */
`include "usb_defines.svh"

module usb_ctrl_transfer (
  input  logic                clock,
  input  logic                reset,
  input  logic [6:0]          usb_addr_i,
  input  logic                tok_valid_i,
  input  usb_pkg::usb_token_t tok_i,
  input  logic                dat_valid_i,
  input  usb_pkg::usb_data_t  dat_i,
  input  logic                hsk_recv_i,
  input  logic                hsk_sent_i,
  input  logic                timeout_i,
  output logic                ctrl_start_o,
  output logic                ctrl_select_o,
  output logic                zdp_o,
  output logic                parity_o,
  output logic                finish_o,
  output usb_pkg::usb_req_t   req_o
);
  import usb_pkg::*;

  // One-hot state encoding
  localparam logic [3:0] ST_IDLE = 4'b0001;
  localparam logic [3:0] ST_SETUP = 4'b0010;
  localparam logic [3:0] ST_DATA = 4'b0100;
  localparam logic [3:0] ST_STATUS = 4'b1000;

  logic [3:0] state_q;
  logic [3:0] state_d;
  logic       sel_w;
  logic       cap_w;
  logic       data_ack_w;
  logic       end_w;
  logic       abort_w;
  logic       zdp_w;
  logic       start_out_q;
  logic       select_q;
  logic       zdp_q;
  logic       par_q;
  logic       finish_q;
  logic       start_q;
  logic       active_q;
  logic [2:0] ptr_q;
  usb_setup_u setup_q;

  // SETUP to our address, endpoint 0, only from idle
  assign sel_w = state_q == ST_IDLE && tok_valid_i && tok_i.pid == `USB_PID_SETUP &&
                 tok_i.addr == usb_addr_i && (!`USB_EP0_ONLY || tok_i.endp == 4'd0);

  // DATA0 bytes of the setup packet, until all are in
  assign cap_w = state_q == ST_SETUP && dat_valid_i && dat_i.pid == `USB_PID_DATA0 &&
                 !active_q;

  // Data stage ack comes from whoever received the data
  // Bit 7 of the request type set means device to host
  assign data_ack_w = setup_q.fields.rtype[7] ? hsk_recv_i : hsk_sent_i;

  // Status stage ends on any handshake or a timeout
  assign end_w = state_q == ST_STATUS && !finish_q &&
                 (hsk_sent_i || hsk_recv_i || timeout_i);

  always_comb begin
    state_d = state_q;
    zdp_w = 1'b0;
    abort_w = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (sel_w) begin
          state_d = ST_SETUP;
        end
      end
      ST_SETUP: begin
        // Leave only once the whole setup packet was acked
        if (hsk_sent_i && active_q) begin
          if (setup_q.fields.length == 16'd0) begin
            state_d = ST_STATUS;
            zdp_w = 1'b1;
          end else begin
            state_d = ST_DATA;
          end
        end else if (timeout_i) begin
          state_d = ST_IDLE;
          abort_w = 1'b1;
        end
      end
      ST_DATA: begin
        if (data_ack_w) begin
          state_d = ST_STATUS;
          // Host sent data, so we owe a zero-length status packet
          zdp_w = hsk_sent_i;
        end else if (timeout_i) begin
          state_d = ST_IDLE;
          abort_w = 1'b1;
        end
      end
      ST_STATUS: begin
        if (finish_q) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
      start_out_q <= 1'b0;
      select_q <= 1'b0;
      zdp_q <= 1'b0;
      par_q <= 1'b0;
      finish_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_out_q <= sel_w;
      zdp_q <= zdp_w;
      finish_q <= end_w;
      // Select drops the cycle after finish
      if (sel_w) begin
        select_q <= 1'b1;
      end else if (finish_q || abort_w) begin
        select_q <= 1'b0;
      end
      // Data toggle tracking
      case (state_q)
        ST_IDLE: par_q <= 1'b0;
        ST_SETUP: if (hsk_sent_i) par_q <= 1'b1;
        ST_DATA: if (hsk_sent_i || hsk_recv_i) par_q <= ~par_q;
        default: par_q <= 1'b1;
      endcase
    end
  end

  // Setup byte pointer and request handshake
  always_ff @(posedge clock) begin
    if (reset) begin
      ptr_q <= 3'd0;
      start_q <= 1'b0;
      active_q <= 1'b0;
    end else begin
      start_q <= cap_w && ptr_q == 3'(`USB_SETUP_BYTES - 1);
      if (sel_w) begin
        ptr_q <= 3'd0;
      end else if (cap_w) begin
        // Short packet, start over with the next DATA0
        if (dat_i.last && ptr_q != 3'(`USB_SETUP_BYTES - 1)) begin
          ptr_q <= 3'd0;
        end else begin
          ptr_q <= ptr_q + 3'd1;
        end
      end
      if (cap_w && ptr_q == 3'(`USB_SETUP_BYTES - 1)) begin
        active_q <= 1'b1;
      end else if (finish_q || abort_w) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cap_w) begin
      setup_q.bytes[ptr_q] <= dat_i.data;
    end
  end

  assign ctrl_start_o = start_out_q;
  assign ctrl_select_o = select_q;
  assign zdp_o = zdp_q;
  assign parity_o = par_q;
  assign finish_o = finish_q;
  assign req_o.setup = setup_q;
  assign req_o.start = start_q;
  assign req_o.active = active_q;

  a_state_onehot : assert property (@(posedge clock) disable iff (reset)
    $onehot(state_q));

  // Finish closes an open transfer, and select follows it down
  a_finish_in_select : assert property (@(posedge clock) disable iff (reset)
    finish_o |-> ctrl_select_o ##1 !ctrl_select_o);

endmodule

/* src/usb_defines.svh */
`ifndef USB_DEFINES_SVH
`define USB_DEFINES_SVH

// Token PIDs, low nibble of the PID byte
`define USB_PID_SETUP 4'b1101
`define USB_PID_IN 4'b1001
`define USB_PID_OUT 4'b0001

// Data PIDs
`define USB_PID_DATA0 4'b0011
`define USB_PID_DATA1 4'b1011

// Handshake PIDs
`define USB_PID_ACK 4'b0010
`define USB_PID_NAK 4'b1010
`define USB_PID_STALL 4'b1110

// Standard request codes, second byte of the setup packet
`define USB_REQ_GET_STATUS 8'h00
`define USB_REQ_SET_ADDRESS 8'h05
`define USB_REQ_SET_CONFIGURATION 8'h09

// Setup packet length in bytes
`define USB_SETUP_BYTES 8

// Set to 1 so that SETUP is only taken on endpoint 0
`define USB_EP0_ONLY 1'b1

`endif

/* src/usb_pkg.sv */
`include "usb_defines.svh"

package usb_pkg;

  // Decoded token packet
  typedef struct packed {
    logic [3:0] pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } usb_token_t;

  // One payload byte, tagged with its DATA0/DATA1 PID
  typedef struct packed {
    logic [7:0] data;
    logic [3:0] pid;
    logic       last;
  } usb_data_t;

  // Setup packet
  // Byte view is filled in bus order, byte 0 lands in the low bits
  // Field view sees the little-endian 16-bit words directly
  typedef union packed {
    logic [`USB_SETUP_BYTES-1:0][7:0] bytes;
    struct packed {
      logic [15:0] length;
      logic [15:0] index;
      logic [15:0] value;
      logic [7:0]  request;
      logic [7:0]  rtype;
    } fields;
  } usb_setup_u;

  // Request handed to the standard-request stage
  // start pulses once all setup bytes are in, active spans the transfer
  typedef struct packed {
    usb_setup_u setup;
    logic       start;
    logic       active;
  } usb_req_t;

endpackage

/* src/usb_std_request.sv */
`include "usb_defines.svh"

module usb_std_request (
  input  logic              clock,
  input  logic              reset,
  input  usb_pkg::usb_req_t req_i,
  input  logic              finish_i,
  output logic [6:0]        usb_addr_o,
  output logic              configured_o,
  output logic              stall_o
);

  logic [7:0]  request_w;
  logic [15:0] value_w;
  logic        std_w;
  logic        is_set_addr_w;
  logic        is_set_cfg_w;
  logic        is_get_status_w;
  logic        supported_w;
  logic [6:0]  addr_q;
  logic [6:0]  pend_addr_q;
  logic        pend_q;
  logic        cfg_q;
  logic        stall_q;

  assign request_w = req_i.setup.fields.request;
  assign value_w = req_i.setup.fields.value;

  // Type bits 6:5 are zero for standard requests
  assign std_w = req_i.setup.fields.rtype[6:5] == 2'b00;

  assign is_set_addr_w = std_w && request_w == `USB_REQ_SET_ADDRESS;
  assign is_set_cfg_w = std_w && request_w == `USB_REQ_SET_CONFIGURATION;
  assign is_get_status_w = std_w && request_w == `USB_REQ_GET_STATUS;
  assign supported_w = is_set_addr_w || is_set_cfg_w || is_get_status_w;

  always_ff @(posedge clock) begin
    if (reset) begin
      addr_q <= 7'd0;
      pend_q <= 1'b0;
      cfg_q <= 1'b0;
      stall_q <= 1'b0;
    end else begin
      if (req_i.start) begin
        pend_q <= is_set_addr_w;
        stall_q <= !supported_w;
        // Any nonzero configuration value counts as configured
        if (is_set_cfg_w) begin
          cfg_q <= value_w[7:0] != 8'd0;
        end
      end else if (finish_i || !req_i.active) begin
        // Transfer over or aborted
        pend_q <= 1'b0;
        stall_q <= 1'b0;
      end
      // New address only after the status stage, which still
      // runs at the old one
      if (finish_i && pend_q) begin
        addr_q <= pend_addr_q;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_i.start && is_set_addr_w) begin
      pend_addr_q <= value_w[6:0];
    end
  end

  assign usb_addr_o = addr_q;
  assign configured_o = cfg_q;
  assign stall_o = stall_q;

  // Address only moves at the end of a SET_ADDRESS transfer
  a_addr_commit : assert property (@(posedge clock) disable iff (reset)
    $changed(addr_q) |-> $past(finish_i && req_i.active &&
                               request_w == `USB_REQ_SET_ADDRESS));

endmodule

/* src/usb_token_decoder.sv */
`include "usb_defines.svh"

module usb_token_decoder (
  input  logic                clock,
  input  logic                reset,
  input  logic                rx_valid_i,
  input  logic                rx_last_i,
  input  logic [7:0]          rx_data_i,
  output logic                tok_valid_o,
  output usb_pkg::usb_token_t tok_o,
  output logic                dat_valid_o,
  output usb_pkg::usb_data_t  dat_o,
  output logic                hsk_recv_o,
  output logic                pid_error_o
);
  import usb_pkg::*;

  // Byte position inside the packet, parks at 3 on long payloads
  logic [1:0] pos_q;
  // Rest of a packet with a bad PID is thrown away
  logic       drop_q;
  logic [3:0] pid_q;
  logic [7:0] tok_lo_q;
  logic       first_w;
  logic       body_w;
  logic       pid_ok_w;
  logic       is_token_w;
  logic       is_data_w;
  logic       tok_valid_q;
  logic       dat_valid_q;
  logic       hsk_q;
  logic       err_q;
  usb_token_t tok_q;
  usb_data_t  dat_q;

  assign first_w = rx_valid_i && pos_q == 2'd0;
  assign body_w = rx_valid_i && pos_q != 2'd0 && !drop_q;

  // Upper nibble must be the complement of the lower one
  assign pid_ok_w = rx_data_i[7:4] == ~rx_data_i[3:0];

  assign is_token_w = pid_q == `USB_PID_SETUP || pid_q == `USB_PID_IN ||
                      pid_q == `USB_PID_OUT;
  assign is_data_w = pid_q == `USB_PID_DATA0 || pid_q == `USB_PID_DATA1;

  // Packet framing
  always_ff @(posedge clock) begin
    if (reset) begin
      pos_q <= 2'd0;
      drop_q <= 1'b0;
    end else if (rx_valid_i) begin
      if (rx_last_i) begin
        pos_q <= 2'd0;
        drop_q <= 1'b0;
      end else begin
        if (pos_q != 2'd3) begin
          pos_q <= pos_q + 2'd1;
        end
        if (first_w) begin
          drop_q <= !pid_ok_w;
        end
      end
    end
  end

  // PID of the current packet and the first token byte
  always_ff @(posedge clock) begin
    if (first_w && pid_ok_w) begin
      pid_q <= rx_data_i[3:0];
    end
    if (body_w && pos_q == 2'd1) begin
      tok_lo_q <= rx_data_i;
    end
  end

  // Event pulses, one cycle after the byte that completes them
  always_ff @(posedge clock) begin
    if (reset) begin
      err_q <= 1'b0;
      hsk_q <= 1'b0;
      tok_valid_q <= 1'b0;
      dat_valid_q <= 1'b0;
    end else begin
      err_q <= first_w && !pid_ok_w;
      hsk_q <= first_w && pid_ok_w && rx_last_i && rx_data_i[3:0] == `USB_PID_ACK;
      // Token is exactly PID plus two bytes
      tok_valid_q <= body_w && is_token_w && pos_q == 2'd2 && rx_last_i;
      dat_valid_q <= body_w && is_data_w;
    end
  end

  // Token fields come from the low 11 bits, CRC5 is ignored
  always_ff @(posedge clock) begin
    if (body_w && pos_q == 2'd2) begin
      tok_q.pid <= pid_q;
      tok_q.addr <= tok_lo_q[6:0];
      tok_q.endp <= {rx_data_i[2:0], tok_lo_q[7]};
    end
    if (body_w) begin
      dat_q.data <= rx_data_i;
      dat_q.pid <= pid_q;
      dat_q.last <= rx_last_i;
    end
  end

  assign tok_valid_o = tok_valid_q;
  assign tok_o = tok_q;
  assign dat_valid_o = dat_valid_q;
  assign dat_o = dat_q;
  assign hsk_recv_o = hsk_q;
  assign pid_error_o = err_q;

  // A byte is either token or payload, never both
  a_tok_dat_excl : assert property (@(posedge clock) disable iff (reset)
    !(tok_valid_o && dat_valid_o));

endmodule

/* testbench/usb_ctrl_tb.sv */
module usb_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 20;
  localparam int CYCLES_PER_LINE = 200;
  localparam string TRACE_FILE = "testbench/usb_ctrl_trace.txt";

  logic       clock;
  logic       reset;
  logic       rx_valid_i;
  logic       rx_last_i;
  logic [7:0] rx_data_i;
  logic       hsk_sent_i;
  logic       timeout_i;
  logic       ctrl_start_o;
  logic       ctrl_select_o;
  logic       zdp_o;
  logic       parity_o;
  logic       finish_o;
  logic       pid_error_o;
  logic [6:0] usb_addr_o;
  logic       configured_o;
  logic       stall_o;

  // Pulse counters, cleared after every expect line
  int zdp_pulses;
  int pid_error_pulses;
  int start_pulses;

  int error_count;
  int reported_errors;
  int test_count;
  int failed_tests;
  int trace_lines;

  // Previous cycle of the transfer framing signals
  logic select_seen;
  logic finish_seen;
  logic timeout_seen;

  // Bytes of the packet being sent
  logic [7:0] pkt_buf [0:15];

  usb_ctrl_top UUT (
    .clock        (clock),
    .reset        (reset),
    .rx_valid_i   (rx_valid_i),
    .rx_last_i    (rx_last_i),
    .rx_data_i    (rx_data_i),
    .hsk_sent_i   (hsk_sent_i),
    .timeout_i    (timeout_i),
    .ctrl_start_o (ctrl_start_o),
    .ctrl_select_o(ctrl_select_o),
    .zdp_o        (zdp_o),
    .parity_o     (parity_o),
    .finish_o     (finish_o),
    .pid_error_o  (pid_error_o),
    .usb_addr_o   (usb_addr_o),
    .configured_o (configured_o),
    .stall_o      (stall_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Pulses are seen on the rising edge, after the DUT settled
  always @(posedge clock) begin
    if (!reset) begin
      if (zdp_o) zdp_pulses = zdp_pulses + 1;
      if (pid_error_o) pid_error_pulses = pid_error_pulses + 1;
      if (ctrl_start_o) start_pulses = start_pulses + 1;
    end
  end

  // Select frames each transfer
  // Up with the start pulse, down right after finish or an aborting timeout
  always @(posedge clock) begin
    if (reset) begin
      select_seen = 1'b0;
      finish_seen = 1'b0;
      timeout_seen = 1'b0;
    end else begin
      if (ctrl_start_o && !ctrl_select_o) begin
        $display("ctrl_select_o stayed low during a ctrl_start_o pulse at t=%0t",
                 $time);
        error_count++;
      end
      if (ctrl_select_o && !select_seen && !ctrl_start_o) begin
        $display("ctrl_select_o rose without a ctrl_start_o pulse at t=%0t", $time);
        error_count++;
      end
      if (finish_o && !ctrl_select_o) begin
        $display("finish_o pulsed outside a control transfer at t=%0t", $time);
        error_count++;
      end
      if (finish_seen && ctrl_select_o) begin
        $display("ctrl_select_o stayed high after finish_o at t=%0t", $time);
        error_count++;
      end
      if (select_seen && !ctrl_select_o && !finish_seen && !timeout_seen) begin
        $display("ctrl_select_o fell without finish_o or a timeout at t=%0t", $time);
        error_count++;
      end
      select_seen = ctrl_select_o;
      finish_seen = finish_o;
      timeout_seen = timeout_i;
    end
  end

  task automatic addr_compare(input string name, input logic [6:0] exp,
                              input logic [6:0] act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic flag_compare(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic count_compare(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      error_count++;
    end
  endtask

  // One byte per cycle, last flagged on the final byte
  task automatic send_packet(input int len);
    int i;
    for (i = 0; i < len; i++) begin
      @(posedge clock);
      rx_valid_i <= 1'b1;
      rx_data_i <= pkt_buf[i];
      rx_last_i <= (i == len - 1);
    end
    @(posedge clock);
    rx_valid_i <= 1'b0;
    rx_last_i <= 1'b0;
  endtask

  // One-cycle pulse on the transmit side inputs
  task automatic drive_event(input string which);
    @(posedge clock);
    if (which == "hsk_sent") begin
      hsk_sent_i <= 1'b1;
    end else if (which == "timeout") begin
      timeout_i <= 1'b1;
    end else begin
      $display("Unknown event %s in the trace", which);
      error_count++;
    end
    @(posedge clock);
    hsk_sent_i <= 1'b0;
    timeout_i <= 1'b0;
  endtask

  // Sampled on the falling edge, away from the driving edge
  task automatic expect_outputs(input string name, input int e_addr, input int e_cfg,
                                input int e_stall, input int e_par, input int e_zdp,
                                input int e_err, input int e_start);
    @(negedge clock);
    addr_compare("usb_addr_o", e_addr[6:0], usb_addr_o);
    flag_compare("configured_o", e_cfg[0], configured_o);
    flag_compare("stall_o", e_stall[0], stall_o);
    flag_compare("parity_o", e_par[0], parity_o);
    count_compare("zdp_o pulses", e_zdp, zdp_pulses);
    count_compare("pid_error_o pulses", e_err, pid_error_pulses);
    count_compare("ctrl_start_o pulses", e_start, start_pulses);
    zdp_pulses = 0;
    pid_error_pulses = 0;
    start_pulses = 0;
    test_count++;
    // Framing errors since the last test count against this one
    if (error_count != reported_errors) begin
      failed_tests++;
      $display("Test %0d %s: FAILED", test_count, name);
    end else begin
      $display("Test %0d %s: ok", test_count, name);
    end
    reported_errors = error_count;
  endtask

  initial begin : watchdog
    wait (trace_lines > 0);
    #(trace_lines * CYCLES_PER_LINE * CLK_PERIOD);
    $display("Timeout: the trace did not finish within %0d cycles",
             trace_lines * CYCLES_PER_LINE);
    $display("Test failures found");
    $finish;
  end

  initial begin : run_trace
    int fd;
    int code;
    int len;
    int i;
    int value;
    int cycles;
    int e_addr;
    int e_cfg;
    int e_stall;
    int e_par;
    int e_zdp;
    int e_err;
    int e_start;
    string cmd;
    string arg;
    string line;
    reset = 1'b1;
    rx_valid_i = 1'b0;
    rx_last_i = 1'b0;
    rx_data_i = 8'h00;
    hsk_sent_i = 1'b0;
    timeout_i = 1'b0;
    zdp_pulses = 0;
    pid_error_pulses = 0;
    start_pulses = 0;
    error_count = 0;
    reported_errors = 0;
    test_count = 0;
    failed_tests = 0;
    trace_lines = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      error_count++;
    end else begin
      // Line count sets the watchdog limit
      while ($fgets(line, fd) != 0) begin
        trace_lines++;
      end
      $fclose(fd);
      fd = $fopen(TRACE_FILE, "r");
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd.getc(0) == "#") begin
          code = $fgets(line, fd);
        end else if (cmd == "P") begin
          code = $fscanf(fd, "%d", len);
          for (i = 0; i < len; i++) begin
            code = $fscanf(fd, "%h", value);
            pkt_buf[i] = value[7:0];
          end
          send_packet(len);
        end else if (cmd == "E") begin
          code = $fscanf(fd, "%s", arg);
          drive_event(arg);
        end else if (cmd == "W") begin
          code = $fscanf(fd, "%d", cycles);
          repeat (cycles) @(posedge clock);
        end else if (cmd == "X") begin
          code = $fscanf(fd, "%s %h %h %h %h %d %d %d", arg, e_addr, e_cfg, e_stall,
                         e_par, e_zdp, e_err, e_start);
          if (code != 8) begin
            $display("An expect line in the trace is incomplete");
            error_count++;
          end else begin
            expect_outputs(arg, e_addr, e_cfg, e_stall, e_par, e_zdp, e_err, e_start);
          end
        end else begin
          $display("Unknown command %s in the trace", cmd);
          error_count++;
        end
      end
      $fclose(fd);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* testbench/usb_ctrl_trace.txt */
# P n bytes: packet of n hex bytes | E hsk_sent or timeout | W n: wait n cycles
# X test addr configured stall parity zdp_pulses pid_error_pulses start_pulses
X after_reset 00 0 0 0 0 0 0
# SET_ADDRESS 5 at address 0, no data stage
P 3 2D 00 10
P 9 C3 00 05 05 00 00 00 00 00
E hsk_sent
P 1 D2
W 3
X set_address 05 0 0 0 1 0 1
# SETUP to the old address is ignored
P 3 2D 00 10
W 3
X old_address 05 0 0 0 0 0 0
# SET_CONFIGURATION 1 then 0 at address 5
P 3 2D 05 E8
P 9 C3 00 09 01 00 00 00 00 00
E hsk_sent
P 1 D2
W 3
X set_config_1 05 1 0 0 1 0 1
P 3 2D 05 E8
P 9 C3 00 09 00 00 00 00 00 00
E hsk_sent
P 1 D2
W 3
X set_config_0 05 0 0 0 1 0 1
# GET_STATUS, two bytes device to host
P 3 2D 05 E8
P 9 C3 80 00 00 00 00 00 02 00
E hsk_sent
W 2
X get_status_setup 05 0 0 1 0 0 1
P 3 69 05 E8
P 1 D2
W 1
X get_status_data 05 0 0 0 0 0 0
E hsk_sent
W 3
X get_status_done 05 0 0 0 0 0 0
# SET_FEATURE is not supported and stalls until the status handshake
P 3 2D 05 E8
P 9 C3 00 03 01 00 00 00 00 00
E hsk_sent
W 2
X stall_setup 05 0 1 1 1 0 1
P 1 D2
W 3
X stall_finish 05 0 0 0 0 0 0
# GET_DESCRIPTOR data stage times out
P 3 2D 05 E8
P 9 C3 80 06 00 01 00 00 12 00
E hsk_sent
E timeout
W 3
X data_timeout 05 0 0 0 0 0 1
P 3 2D 05 E8
P 9 C3 00 09 01 00 00 00 00 00
E hsk_sent
P 1 D2
W 3
X after_timeout 05 1 0 0 1 0 1
# Broken PID complement, whole packet dropped
P 3 2E 05 E8
W 3
X bad_pid 05 1 0 0 0 1 0
